//--- Bender.yml
package:
  name: vector_exec
  authors: []

dependencies: {}

sources:
  - files:
      - design/vexec_pkg.sv
      - design/vexec_dispatch.sv
      - design/lane_divider.sv
      - design/vector_lane.sv
      - design/vexec_collect.sv
      - design/vector_exec_top.sv
  - target: test
    files:
      - verification/tb_vector_exec.sv

# simulation top: tb_vector_exec, RTL top: vector_exec_top

//--- design/lane_divider.sv
`timescale 1ns/1ps
// iterative signed divider, restoring on magnitudes, one bit per cycle
// RISC-V results for divide by zero and overflow
module lane_divider (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             start,
  input  logic             rem_sel,
  input  vexec_pkg::elem_t dividend,
  input  vexec_pkg::elem_t divisor,
  output logic             done,
  output vexec_pkg::elem_t quotient_or_rem
);

  localparam int ELEN  = vexec_pkg::ELEN;
  localparam int CNT_W = $clog2(ELEN);

  typedef enum logic [1:0] {IDLE, RUN, FIX} state_e;

  state_e           state_q;
  logic [CNT_W-1:0] cnt_q;  // iterations left in RUN
  logic             load;
  vexec_pkg::elem_t rem_q, quo_q, div_q, dividend_q;
  logic             q_neg_q, r_neg_q, div_zero_q, ovf_q, rem_sel_q;
  vexec_pkg::elem_t a_mag, b_mag, step_rem, step_quo, step_div;
  logic [ELEN:0]    shifted, diff;
  vexec_pkg::elem_t next_rem, next_quo, q_fixed, r_fixed;

  assign load  = (state_q == IDLE) && start;
  assign a_mag = dividend[ELEN-1] ? -dividend : dividend;
  assign b_mag = divisor[ELEN-1] ? -divisor : divisor;

  // first step taken on the load edge straight from the inputs
  assign step_rem = (state_q == IDLE) ? '0 : rem_q;
  assign step_quo = (state_q == IDLE) ? a_mag : quo_q;
  assign step_div = (state_q == IDLE) ? b_mag : div_q;
  assign shifted  = {step_rem, step_quo[ELEN-1]};
  assign diff     = shifted - {1'b0, step_div};
  assign next_rem = diff[ELEN] ? shifted[ELEN-1:0] : diff[ELEN-1:0];  // restore on borrow
  assign next_quo = {step_quo[ELEN-2:0], ~diff[ELEN]};

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: if (start) begin
          state_q <= RUN;
          cnt_q   <= CNT_W'(ELEN - 2);  // remaining steps after load
        end
        RUN: if (cnt_q == '0) state_q <= FIX;
             else cnt_q <= cnt_q - 1'b1;
        FIX:     state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (load) begin
      dividend_q <= dividend;
      div_q      <= b_mag;
      q_neg_q    <= dividend[ELEN-1] ^ divisor[ELEN-1];
      r_neg_q    <= dividend[ELEN-1];  // remainder follows dividend sign
      div_zero_q <= (divisor == '0);
      ovf_q      <= (dividend == {1'b1, {(ELEN-1){1'b0}}}) && (divisor == '1);
      rem_sel_q  <= rem_sel;
    end
    if (load || (state_q == RUN)) begin
      rem_q <= next_rem;
      quo_q <= next_quo;
    end
  end

  // sign fixup and corner cases
  always_comb begin
    q_fixed = q_neg_q ? -quo_q : quo_q;
    r_fixed = r_neg_q ? -rem_q : rem_q;
    if (div_zero_q) begin
      q_fixed = '1;
      r_fixed = dividend_q;
    end else if (ovf_q) begin
      q_fixed = dividend_q;
      r_fixed = '0;
    end
  end

  assign done            = (state_q == FIX);  // single FIX cycle
  assign quotient_or_rem = rem_sel_q ? r_fixed : q_fixed;

endmodule

//--- design/vector_exec_top.sv
`timescale 1ns/1ps
// vector execute cluster top: dispatcher, generated lanes, collector
module vector_exec_top #(
  parameter int NUM_LANES = 4
) (
  input  logic                             CLK,
  input  logic                             nRST,
  input  logic                             in_req,
  output logic                             in_ack,
  input  vexec_pkg::fu_type_e              in_fu_type,
  input  vexec_pkg::vop_t                  in_op,
  input  logic [$clog2(NUM_LANES+1)-1:0]   in_vl,
  input  vexec_pkg::elem_t [NUM_LANES-1:0] in_src_a,
  input  vexec_pkg::elem_t [NUM_LANES-1:0] in_src_b,
  output logic                             out_req,
  input  logic                             out_ack,
  output vexec_pkg::elem_t [NUM_LANES-1:0] out_result
);

  logic [NUM_LANES-1:0]             lane_start, active_mask, lane_valid;
  logic                             issue, lane_take;
  vexec_pkg::fu_type_e              op_fu;     // broadcast
  vexec_pkg::vop_t                  op_code;   // broadcast
  vexec_pkg::elem_t [NUM_LANES-1:0] op_src_a, op_src_b, lane_result;

  vexec_dispatch #(.NUM_LANES(NUM_LANES)) u_dispatch (
    .CLK, .nRST, .in_req, .in_fu_type, .in_op, .in_vl, .in_src_a, .in_src_b,
    .lane_take, .in_ack, .lane_start, .active_mask, .issue,
    .op_fu, .op_code, .op_src_a, .op_src_b
  );

  // one lane per element, take fanned to all
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    vector_lane u_lane (
      .CLK    (CLK),
      .nRST   (nRST),
      .start  (lane_start[i]),
      .fu     (op_fu),
      .op     (op_code),
      .src_a  (op_src_a[i]),
      .src_b  (op_src_b[i]),
      .take   (lane_take),
      .valid  (lane_valid[i]),
      .result (lane_result[i])
    );
  end

  vexec_collect #(.NUM_LANES(NUM_LANES)) u_collect (
    .CLK, .nRST, .lane_valid, .lane_result, .active_mask, .issue, .out_ack,
    .lane_take, .out_req, .out_result
  );

endmodule

//--- design/vector_lane.sv
`timescale 1ns/1ps
// one vector lane: arithmetic unit, two-stage multiplier,
// divider start logic and result select held until take
module vector_lane (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                start,
  input  vexec_pkg::fu_type_e fu,
  input  vexec_pkg::vop_t     op,
  input  vexec_pkg::elem_t    src_a,
  input  vexec_pkg::elem_t    src_b,
  input  logic                take,
  output logic                valid,
  output vexec_pkg::elem_t    result
);

  localparam int ELEN = vexec_pkg::ELEN;
  localparam int HALF = ELEN / 2;

  vexec_pkg::fu_type_e fu_q;  // unit of the op in flight
  logic                au, mlu, dv;
  logic                div_start, div_done, mul_p1;
  vexec_pkg::elem_t    arith_res, arith_q;
  vexec_pkg::elem_t    mul_lo_q, mul_cross_q, mul_q;
  vexec_pkg::elem_t    div_res, div_q;

  // arithmetic unit, combinational
  always_comb begin
    case (op)
      vexec_pkg::OP_ADD: arith_res = src_a + src_b;
      vexec_pkg::OP_SUB: arith_res = src_a - src_b;
      vexec_pkg::OP_AND: arith_res = src_a & src_b;
      vexec_pkg::OP_OR:  arith_res = src_a | src_b;
      vexec_pkg::OP_XOR: arith_res = src_a ^ src_b;
      vexec_pkg::OP_MIN: arith_res = ($signed(src_a) < $signed(src_b)) ? src_a : src_b;
      vexec_pkg::OP_MAX: arith_res = ($signed(src_a) > $signed(src_b)) ? src_a : src_b;
      default:           arith_res = '0;
    endcase
  end

  assign div_start = start && (fu == vexec_pkg::FU_DIV);  // one-cycle strobe

  lane_divider u_div (
    .CLK             (CLK),
    .nRST            (nRST),
    .start           (div_start),
    .rem_sel         (op == vexec_pkg::OP_REM),
    .dividend        (src_a),
    .divisor         (src_b),
    .done            (div_done),
    .quotient_or_rem (div_res)
  );

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      fu_q   <= vexec_pkg::FU_ARITH;
      mul_p1 <= 1'b0;
      valid  <= 1'b0;
    end else begin
      mul_p1 <= start && (fu == vexec_pkg::FU_MUL);  // stage 1 occupied
      if (start) fu_q <= fu;
      if (take) valid <= 1'b0;
      else if ((start && (fu == vexec_pkg::FU_ARITH)) || mul_p1 || div_done) valid <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (start) begin
      arith_q     <= arith_res;
      // stage 1: low partial product and cross terms
      mul_lo_q    <= src_a[HALF-1:0] * src_b[HALF-1:0];
      mul_cross_q <= src_a[HALF-1:0] * src_b[ELEN-1:HALF] + src_a[ELEN-1:HALF] * src_b[HALF-1:0];
    end
    if (mul_p1) mul_q <= mul_lo_q + {mul_cross_q[HALF-1:0], {HALF{1'b0}}};  // stage 2
    if (div_done) div_q <= div_res;
  end

  // unit outputs ORed by latched type
  assign au  = (fu_q == vexec_pkg::FU_ARITH);
  assign mlu = (fu_q == vexec_pkg::FU_MUL);
  assign dv  = (fu_q == vexec_pkg::FU_DIV);

  assign result = ({ELEN{au}} & arith_q) | ({ELEN{mlu}} & mul_q) | ({ELEN{dv}} & div_q);

endmodule

//--- design/vexec_collect.sv
`timescale 1ns/1ps
// result collector: waits on active lanes, captures the vector,
// four-phase output handshake
module vexec_collect #(
  parameter int NUM_LANES = 4
) (
  input  logic                             CLK,
  input  logic                             nRST,
  input  logic [NUM_LANES-1:0]             lane_valid,
  input  vexec_pkg::elem_t [NUM_LANES-1:0] lane_result,
  input  logic [NUM_LANES-1:0]             active_mask,
  input  logic                             issue,
  input  logic                             out_ack,
  output logic                             lane_take,
  output logic                             out_req,
  output vexec_pkg::elem_t [NUM_LANES-1:0] out_result
);

  typedef enum logic [1:0] {EMPTY, REQ, WAIT_ACK_LOW} state_e;

  state_e               state_q;
  logic                 pending_q;  // op issued, not yet collected
  logic [NUM_LANES-1:0] mask_q;
  logic                 all_valid;

  assign all_valid = &(lane_valid | ~mask_q);  // true at once for empty mask
  assign lane_take = pending_q && all_valid && (state_q == EMPTY);
  assign out_req   = (state_q == REQ);

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state_q   <= EMPTY;
      pending_q <= 1'b0;
      mask_q    <= '0;
    end else begin
      if (issue) begin
        pending_q <= 1'b1;
        mask_q    <= active_mask;
      end else if (lane_take) begin
        pending_q <= 1'b0;
      end
      case (state_q)
        EMPTY:        if (lane_take) state_q <= REQ;
        REQ:          if (out_ack) state_q <= WAIT_ACK_LOW;
        WAIT_ACK_LOW: if (!out_ack) state_q <= EMPTY;  // register free again
        default:      state_q <= EMPTY;
      endcase
    end
  end

  // capture, idle lanes read zero
  always_ff @(posedge CLK) begin
    if (lane_take) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        out_result[i] <= mask_q[i] ? lane_result[i] : '0;
      end
    end
  end

endmodule

//--- design/vexec_dispatch.sv
`timescale 1ns/1ps
// operation dispatcher: four-phase input handshake, operand latch,
// lane start strobes and active-lane mask
module vexec_dispatch #(
  parameter int NUM_LANES = 4
) (
  input  logic                                   CLK,
  input  logic                                   nRST,
  input  logic                                   in_req,
  input  vexec_pkg::fu_type_e                    in_fu_type,
  input  vexec_pkg::vop_t                        in_op,
  input  logic [$clog2(NUM_LANES+1)-1:0]         in_vl,
  input  vexec_pkg::elem_t [NUM_LANES-1:0]       in_src_a,
  input  vexec_pkg::elem_t [NUM_LANES-1:0]       in_src_b,
  input  logic                                   lane_take,
  output logic                                   in_ack,
  output logic [NUM_LANES-1:0]                   lane_start,
  output logic [NUM_LANES-1:0]                   active_mask,
  output logic                                   issue,
  output vexec_pkg::fu_type_e                    op_fu,
  output vexec_pkg::vop_t                        op_code,
  output vexec_pkg::elem_t [NUM_LANES-1:0]       op_src_a,
  output vexec_pkg::elem_t [NUM_LANES-1:0]       op_src_b
);

  typedef enum logic [1:0] {IDLE, ACKED, WAIT_REQ_LOW} state_e;

  state_e               state_q;
  logic                 lanes_busy;  // set on issue, freed by collector
  logic [NUM_LANES-1:0] vl_mask;
  logic                 accept;

  // thermometer decode, lane i active when i < vl
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      vl_mask[i] = (i < int'(in_vl));
    end
  end

  assign accept = (state_q == IDLE) && in_req && !lanes_busy;
  assign in_ack = (state_q != IDLE);  // high from accept until req seen low

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state_q     <= IDLE;
      lanes_busy  <= 1'b0;
      lane_start  <= '0;
      active_mask <= '0;
      issue       <= 1'b0;
    end else begin
      lane_start <= '0;    // strobes default low
      issue      <= 1'b0;
      case (state_q)
        IDLE: if (accept) begin
          state_q     <= ACKED;
          lane_start  <= vl_mask;  // empty mask when vl is zero
          active_mask <= vl_mask;
          issue       <= 1'b1;
        end
        ACKED:        state_q <= in_req ? WAIT_REQ_LOW : IDLE;
        WAIT_REQ_LOW: if (!in_req) state_q <= IDLE;  // ack drops here
        default:      state_q <= IDLE;
      endcase
      if (accept) lanes_busy <= 1'b1;
      else if (lane_take) lanes_busy <= 1'b0;
    end
  end

  // operands held stable for the lanes after the handshake ends
  always_ff @(posedge CLK) begin
    if (accept) begin
      op_fu    <= in_fu_type;
      op_code  <= in_op;
      op_src_a <= in_src_a;
      op_src_b <= in_src_b;
    end
  end

endmodule

//--- design/vexec_pkg.sv
// element, opcode and functional-unit types shared by the
// dispatcher, the lanes and the collector
package vexec_pkg;

  localparam int ELEN = 32;  // element width

  typedef logic [ELEN-1:0] elem_t;  // one vector element

  // functional-unit selector
  typedef enum logic [1:0] {
    FU_ARITH = 2'd0,
    FU_MUL   = 2'd1,
    FU_DIV   = 2'd2
  } fu_type_e;

  typedef logic [2:0] vop_t;  // op code within one unit

  // arithmetic unit codes
  localparam vop_t OP_ADD = 3'd0;
  localparam vop_t OP_SUB = 3'd1;
  localparam vop_t OP_AND = 3'd2;
  localparam vop_t OP_OR  = 3'd3;
  localparam vop_t OP_XOR = 3'd4;
  localparam vop_t OP_MIN = 3'd5;  // signed
  localparam vop_t OP_MAX = 3'd6;  // signed

  // divide unit codes
  localparam vop_t OP_DIV = 3'd0;  // quotient
  localparam vop_t OP_REM = 3'd1;  // remainder

  // multiply unit takes no code, always low half of product

endpackage

//--- files.f
design/vexec_pkg.sv
design/vexec_dispatch.sv
design/lane_divider.sv
design/vector_lane.sv
design/vexec_collect.sv
design/vector_exec_top.sv
verification/tb_vector_exec.sv

//--- verification/tb_vector_exec.sv
`timescale 1ns/1ps
// testbench for the vector execute cluster: clock, reset, random ops,
// reference model with result queue, compare tasks, watchdog
module tb_vector_exec;

  localparam int NUM_LANES  = 4;
  localparam int VL_W       = $clog2(NUM_LANES + 1);
  localparam int NUM_OPS    = 300;
  localparam int CLK_PERIOD = 8;
  localparam int TIMEOUT_CYCLES = NUM_OPS * (33 + 20);  // worst divide plus handshakes
  localparam int QUIET_CYCLES   = 33 + 20;  // one more divide could surface here

  typedef vexec_pkg::elem_t [NUM_LANES-1:0] vec_t;

  logic                CLK = 1'b0;
  logic                nRST;
  logic                in_req, in_ack, out_req, out_ack;
  vexec_pkg::fu_type_e in_fu_type;
  vexec_pkg::vop_t     in_op;
  logic [VL_W-1:0]     in_vl;
  vec_t                in_src_a, in_src_b, out_result;

  integer seed = 32'h1bd60f7e;
  vec_t   exp_q[$];       // expected vectors in issue order
  int     received = 0;

  vector_exec_top #(.NUM_LANES(NUM_LANES)) uut (
    .CLK, .nRST, .in_req, .in_ack, .in_fu_type, .in_op, .in_vl,
    .in_src_a, .in_src_b, .out_req, .out_ack, .out_result
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_elem(input vexec_pkg::elem_t got, input vexec_pkg::elem_t exp,
                            input int lane);
    if (got !== exp) begin
      $display("FAILED at %0t ns: out_result[%0d] = %h, expected %h", $time, lane, got, exp);
      abort_run();
    end
  endtask

  task automatic check_ack(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  function automatic int rand_below(input int n);
    rand_below = $unsigned($random(seed)) % n;
  endfunction

  // one in eight operands is a corner value
  function automatic vexec_pkg::elem_t rand_operand();
    vexec_pkg::elem_t r;
    r = $random(seed);
    if (r[2:0] == 3'd0) begin
      case (rand_below(3))
        0:       r = 32'h0000_0000;
        1:       r = 32'hffff_ffff;  // minus one
        default: r = 32'h8000_0000;  // most negative
      endcase
    end
    rand_operand = r;
  endfunction

  // reference for one element, from the unit rules
  function automatic vexec_pkg::elem_t lane_model(input vexec_pkg::fu_type_e fu,
      input vexec_pkg::vop_t op, input vexec_pkg::elem_t a, input vexec_pkg::elem_t b);
    vexec_pkg::elem_t q, r, res;
    logic signed [63:0] prod;
    res = '0;
    if (fu == vexec_pkg::FU_MUL) begin
      prod = $signed(a) * $signed(b);
      res  = prod[31:0];  // low word only
    end else if (fu == vexec_pkg::FU_DIV) begin
      if (b == 32'h0) begin
        q = 32'hffff_ffff;
        r = a;
      end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
        q = a;  // overflow case
        r = 32'h0;
      end else begin
        q = $signed(a) / $signed(b);  // truncates toward zero
        r = $signed(a) % $signed(b);
      end
      res = (op == vexec_pkg::OP_REM) ? r : q;
    end else begin
      case (op)
        vexec_pkg::OP_ADD: res = a + b;
        vexec_pkg::OP_SUB: res = a - b;
        vexec_pkg::OP_AND: res = a & b;
        vexec_pkg::OP_OR:  res = a | b;
        vexec_pkg::OP_XOR: res = a ^ b;
        vexec_pkg::OP_MIN: res = ($signed(a) <= $signed(b)) ? a : b;
        vexec_pkg::OP_MAX: res = ($signed(a) >= $signed(b)) ? a : b;
        default:           res = '0;
      endcase
    end
    lane_model = res;
  endfunction

  // one op over the input handshake, expected vector queued first
  task automatic send_op();
    vexec_pkg::fu_type_e fu;
    vexec_pkg::vop_t     op;
    int                  vl, hold;
    vec_t                a, b, exp;
    fu = vexec_pkg::fu_type_e'(rand_below(3));
    case (fu)
      vexec_pkg::FU_ARITH: op = vexec_pkg::vop_t'(rand_below(7));
      vexec_pkg::FU_DIV:   op = vexec_pkg::vop_t'(rand_below(2));
      default:             op = vexec_pkg::vop_t'(rand_below(8));  // ignored by mul
    endcase
    vl = rand_below(NUM_LANES + 1);
    for (int i = 0; i < NUM_LANES; i++) begin
      a[i] = rand_operand();
      b[i] = rand_operand();
    end
    // most negative over minus one in lane 0, now and then
    if (fu == vexec_pkg::FU_DIV && rand_below(4) == 0) begin
      a[0] = 32'h8000_0000;
      b[0] = 32'hffff_ffff;
    end
    for (int i = 0; i < NUM_LANES; i++) begin
      exp[i] = (i < vl) ? lane_model(fu, op, a[i], b[i]) : '0;  // idle lanes zero
    end
    exp_q.push_back(exp);
    in_fu_type = fu;
    in_op      = op;
    in_vl      = VL_W'(vl);
    in_src_a   = a;
    in_src_b   = b;
    in_req     = 1'b1;
    do @(negedge CLK); while (!in_ack);
    hold = rand_below(3);
    repeat (hold) begin
      @(negedge CLK);
      check_ack(in_ack, 1'b1, "in_ack");  // ack holds while req high
    end
    @(posedge CLK);
    #1 in_req = 1'b0;
    @(negedge CLK);
    check_ack(in_ack, 1'b1, "in_ack");    // falls only once req seen low
    do @(negedge CLK); while (in_ack);
  endtask

  // answer out_req after a random delay, check against queue head
  task automatic take_result();
    vec_t exp;
    int   delay;
    do @(negedge CLK); while (!out_req);
    delay = rand_below(7);
    repeat (delay) @(negedge CLK);
    if (exp_q.size() == 0) begin
      $display("result vector arrived with no operation outstanding at %0t ns", $time);
      abort_run();
    end
    exp = exp_q.pop_front();
    for (int i = 0; i < NUM_LANES; i++) check_elem(out_result[i], exp[i], i);
    received++;
    @(posedge CLK);
    #1 out_ack = 1'b1;
    do @(negedge CLK); while (out_req);
    @(posedge CLK);
    #1 out_ack = 1'b0;
  endtask

  initial begin
    nRST       = 1'b0;
    in_req     = 1'b0;
    in_fu_type = vexec_pkg::FU_ARITH;
    in_op      = '0;
    in_vl      = '0;
    in_src_a   = '0;
    in_src_b   = '0;
    out_ack    = 1'b0;
    repeat (8) @(posedge CLK);
    #1 nRST = 1'b1;
    @(negedge CLK);
    check_ack(in_ack, 1'b0, "in_ack");   // quiet before first request
    check_ack(out_req, 1'b0, "out_req");
    fork
      begin
        for (int n = 0; n < NUM_OPS; n++) begin
          @(posedge CLK);
          #1 send_op();
        end
      end
      begin
        repeat (NUM_OPS) take_result();
      end
    join
    // a repeated vector would raise out_req again
    repeat (QUIET_CYCLES) begin
      @(negedge CLK);
      check_ack(out_req, 1'b0, "out_req");
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

  // watchdog
  initial begin
    #((TIMEOUT_CYCLES + QUIET_CYCLES + 8) * CLK_PERIOD);
    $display("timeout: output handshake stalled after %0d of %0d results", received, NUM_OPS);
    abort_run();
  end

endmodule
